// File: proxy_core.f
hdl/proxy_pkg.sv
hdl/mgmt_regs.sv
hdl/desc_dispatch.sv
hdl/match_lane.sv
hdl/result_merge.sv
hdl/proxy_core.sv
bench/proxy_core_assert.sv
bench/proxy_core_tb.sv

// File: Bender.yml
package:
  name: proxy_core

sources:
  - files:
      - hdl/proxy_pkg.sv
      - hdl/mgmt_regs.sv
      - hdl/desc_dispatch.sv
      - hdl/match_lane.sv
      - hdl/result_merge.sv
      - hdl/proxy_core.sv
  - target: test
    files:
      - bench/proxy_core_assert.sv
      - bench/proxy_core_tb.sv

// File: bench/proxy_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module proxy_core_tb;
    import proxy_pkg::*;

    localparam int tbl_depth      = 8;
    localparam int num_random     = 200;
    localparam int num_desc       = num_random + 8;
    localparam int timeout_cycles = num_desc * 40 + 2000;

    logic        axil_if;
    logic        arst_n;
    desc_t       in_desc;
    logic        in_valid;
    logic        in_ready;
    result_t     out_res;
    logic        out_valid;
    logic        out_ready;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    integer      seed;
    int          errors;
    int          checks;
    int          err_mark;
    int          pending;
    int          fwd_seen;
    int          punt_seen;
    logic        bp_en;
    result_t     exp_q [$];
    result_t     exp_res;
    desc_t       d;
    logic [31:0] rd;
    logic        ref_valid [tbl_depth];
    logic [15:0] ref_key [tbl_depth];
    action_u     ref_act [tbl_depth];
    logic [15:0] key_list [8];

    proxy_core #(
        .num_lanes (4),
        .tbl_depth (tbl_depth)
    ) i_proxy_core (
        .axil_if   (axil_if),
        .arst_n    (arst_n),
        .in_desc   (in_desc),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_res   (out_res),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp)
    );

    always #10 axil_if = ~axil_if;

    // ========================================================================
    // Checking helpers and reference model
    // ========================================================================
    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        $display("Test %-22s %0s", name, (errors == err_mark) ? "ok" : "FAILED");
        err_mark = errors;
    endtask

    // Lowest matching valid index wins, a miss punts
    function automatic action_u ref_action(input logic [15:0] key);
        action_u a;
        logic    found;
        found = 1'b0;
        a     = '0;
        for (int i = 0; i < tbl_depth; i++) begin
            if (!found && ref_valid[i] && ref_key[i] == key) begin
                a     = ref_act[i];
                found = 1'b1;
            end
        end
        if (!found) begin
            a.punt.tag    = 1'b0;
            a.punt.pad    = 3'd0;
            a.punt.reason = 4'd1;
        end
        return a;
    endfunction

    // ========================================================================
    // Bus tasks, entered 1 ns after a rising edge
    // ========================================================================
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        @(posedge axil_if);
        while (!axil_rsp.awready) @(posedge axil_if);
        check_eq(64'(axil_rsp.wready), 64'd1, "wready with awready");
        #1;
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        axil_req.bready  = 1'b1;
        @(posedge axil_if);
        while (!axil_rsp.bvalid) @(posedge axil_if);
        #1;
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        @(posedge axil_if);
        while (!axil_rsp.arready) @(posedge axil_if);
        #1;
        axil_req.arvalid = 1'b0;
        axil_req.rready  = 1'b1;
        @(posedge axil_if);
        while (!axil_rsp.rvalid) @(posedge axil_if);
        data = axil_rsp.rdata;
        #1;
        axil_req.rready = 1'b0;
    endtask

    task automatic set_entry(input int idx, input logic v, input logic [15:0] k,
                             input logic [7:0] a);
        ref_valid[idx] = v;
        ref_key[idx]   = k;
        ref_act[idx]   = a;
        axil_write(8'(4 * idx), {v, 7'd0, a, k});
    endtask

    // Expected result is queued on the transfer edge
    task automatic send_desc(input desc_t dsc);
        result_t r;
        r.desc   = dsc;
        r.act    = ref_action(dsc.key);
        in_desc  = dsc;
        in_valid = 1'b1;
        @(posedge axil_if);
        while (!in_ready) @(posedge axil_if);
        exp_q.push_back(r);
        pending++;
        #1;
        in_valid = 1'b0;
    endtask

    task automatic drain;
        wait (pending == 0);
        repeat (4) @(posedge axil_if);
        #1;
    endtask

    // ========================================================================
    // Output side: back-pressure and compare
    // ========================================================================
    always @(posedge axil_if) begin
        #1;
        out_ready = !bp_en || (($random(seed) & 3) != 0);
    end

    always @(posedge axil_if) begin
        if (arst_n && out_valid && out_ready) begin
            if (pending == 0) begin
                errors++;
                $display("Output at %0t ns had no matching input descriptor", $time);
            end else begin
                exp_res = exp_q.pop_front();
                pending--;
                check_eq(64'(out_res), 64'(exp_res), "result");
                if (exp_res.act.fwd.tag) begin
                    fwd_seen++;
                end else begin
                    punt_seen++;
                end
            end
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge axil_if);
        $display("Run timed out after %0d cycles, traffic did not complete", timeout_cycles);
        $display("Done: errors found");
        $finish;
    end

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        axil_if   = 1'b0;
        arst_n    = 1'b1;
        in_desc   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        axil_req  = '0;
        bp_en     = 1'b0;
        seed      = 32'hf6ce;
        errors    = 0;
        checks    = 0;
        err_mark  = 0;
        pending   = 0;
        fwd_seen  = 0;
        punt_seen = 0;
        key_list  = '{16'h1111, 16'h2222, 16'h3333, 16'habcd, 16'h5555,
                      16'h4444, 16'h7777, 16'h0000};
        #2 arst_n = 1'b0;
        repeat (16) @(posedge axil_if);
        #1 arst_n = 1'b1;

        check_eq(64'(out_valid), 64'd0, "out_valid after reset");
        check_eq(64'(axil_rsp.bvalid), 64'd0, "bvalid after reset");
        check_eq(64'(axil_rsp.rvalid), 64'd0, "rvalid after reset");
        axil_read(reg_fwd_cnt, rd);
        check_eq(64'(rd), 64'd0, "forward counter after reset");
        axil_read(reg_punt_cnt, rd);
        check_eq(64'(rd), 64'd0, "punt counter after reset");
        report_test("reset_state");

        // Entry 2 duplicates key 1111, entries 4 and 7 are invalid
        set_entry(0, 1'b1, 16'h1111, 8'h82);
        set_entry(1, 1'b1, 16'h2222, 8'h05);
        set_entry(2, 1'b1, 16'h1111, 8'h83);
        set_entry(3, 1'b1, 16'h3333, 8'h81);
        set_entry(4, 1'b0, 16'h4444, 8'h80);
        set_entry(5, 1'b1, 16'h5555, 8'h09);
        set_entry(6, 1'b1, 16'habcd, 8'h80);
        set_entry(7, 1'b0, 16'h0000, 8'h83);
        for (int i = 0; i < tbl_depth; i++) begin
            axil_read(8'(4 * i), rd);
            check_eq(64'(rd), 64'({ref_valid[i], 7'd0, ref_act[i], ref_key[i]}), "readback");
        end
        report_test("table_readback");

        for (int i = 0; i < 5; i++) begin
            d = {2'(i), key_list[i], 14'(100 + i)};
            send_desc(d);
        end
        drain();
        report_test("table_hits");

        for (int i = 5; i < 8; i++) begin
            d = {2'(i), key_list[i], 14'(200 + i)};
            send_desc(d);
        end
        drain();
        report_test("table_miss");

        bp_en = 1'b1;
        for (int n = 0; n < num_random; n++) begin
            d.src_port = 2'($random(seed));
            d.key      = key_list[$random(seed) & 7];
            d.len      = 14'($random(seed));
            send_desc(d);
            if (($random(seed) & 7) == 0) begin
                @(posedge axil_if);
                #1;
            end
        end
        drain();
        bp_en = 1'b0;
        check_eq(64'(out_valid), 64'd0, "no result left after drain");
        report_test("random_stream");

        axil_read(reg_fwd_cnt, rd);
        check_eq(64'(rd), 64'(fwd_seen), "forward counter");
        axil_read(reg_punt_cnt, rd);
        check_eq(64'(rd), 64'(punt_seen), "punt counter");
        report_test("counters");

        check_eq(64'(i_proxy_core.i_proxy_core_assert.fail_count), 64'd0,
                 "bound assertion failures");
        report_test("assertions");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/proxy_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module proxy_core_assert (
    input logic                 axil_if,
    input logic                 arst_n,
    input logic                 out_valid,
    input logic                 out_ready,
    input proxy_pkg::result_t   out_res,
    input proxy_pkg::axil_req_t axil_req,
    input proxy_pkg::axil_rsp_t axil_rsp
);
    int fail_count = 0;

    // Stalled output keeps its item
    a_out_hold: assert property (@(posedge axil_if) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_res))
        else begin
            $error("out_valid dropped or out_res changed while out_ready was low");
            fail_count++;
        end

    a_b_hold: assert property (@(posedge axil_if) disable iff (!arst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else begin
            $error("bvalid dropped before bready");
            fail_count++;
        end

    a_r_hold: assert property (@(posedge axil_if) disable iff (!arst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
        else begin
            $error("rvalid dropped before rready");
            fail_count++;
        end

    a_reset_idle: assert property (@(posedge axil_if) !arst_n |-> !out_valid)
        else begin
            $error("out_valid high during reset");
            fail_count++;
        end

endmodule

bind proxy_core proxy_core_assert i_proxy_core_assert (
    .axil_if   (axil_if),
    .arst_n    (arst_n),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_res   (out_res),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp)
);

`default_nettype wire

// File: hdl/proxy_core.sv
`timescale 1ns/1ps
`default_nettype none

module proxy_core #(
    parameter int num_lanes = 4,
    parameter int tbl_depth = 8
) (
    input  logic                 axil_if,
    input  logic                 arst_n,
    input  proxy_pkg::desc_t     in_desc,
    input  logic                 in_valid,
    output logic                 in_ready,
    output proxy_pkg::result_t   out_res,
    output logic                 out_valid,
    input  logic                 out_ready,
    input  proxy_pkg::axil_req_t axil_req,
    output proxy_pkg::axil_rsp_t axil_rsp
);
    import proxy_pkg::*;

    tbl_entry_t [tbl_depth-1:0] tbl;
    desc_t      [num_lanes-1:0] lane_desc;
    logic       [num_lanes-1:0] lane_in_valid;
    logic       [num_lanes-1:0] lane_in_ready;
    result_t    [num_lanes-1:0] lane_res;
    logic       [num_lanes-1:0] lane_out_valid;
    logic       [num_lanes-1:0] lane_out_ready;
    logic                       out_fire;

    assign out_fire = out_valid & out_ready;

    mgmt_regs #(
        .tbl_depth (tbl_depth)
    ) i_mgmt_regs (
        .axil_if    (axil_if),
        .arst_n     (arst_n),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .tbl        (tbl),
        .out_fire   (out_fire),
        .out_action (out_res.act)
    );

    desc_dispatch #(
        .num_lanes (num_lanes)
    ) i_desc_dispatch (
        .axil_if       (axil_if),
        .arst_n        (arst_n),
        .in_desc       (in_desc),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .lane_desc     (lane_desc),
        .lane_in_valid (lane_in_valid),
        .lane_in_ready (lane_in_ready)
    );

    // ========================================================================
    // Match lanes
    // ========================================================================
    for (genvar g = 0; g < num_lanes; g++) begin : g_lane
        match_lane #(
            .tbl_depth (tbl_depth)
        ) i_match_lane (
            .axil_if   (axil_if),
            .arst_n    (arst_n),
            .tbl       (tbl),
            .desc      (lane_desc[g]),
            .in_valid  (lane_in_valid[g]),
            .in_ready  (lane_in_ready[g]),
            .res       (lane_res[g]),
            .out_valid (lane_out_valid[g]),
            .out_ready (lane_out_ready[g])
        );
    end

    result_merge #(
        .num_lanes (num_lanes)
    ) i_result_merge (
        .axil_if        (axil_if),
        .arst_n         (arst_n),
        .lane_res       (lane_res),
        .lane_out_valid (lane_out_valid),
        .lane_out_ready (lane_out_ready),
        .out_res        (out_res),
        .out_valid      (out_valid),
        .out_ready      (out_ready)
    );

endmodule

`default_nettype wire

// File: hdl/result_merge.sv
`timescale 1ns/1ps
`default_nettype none

module result_merge #(
    parameter int num_lanes = 4
) (
    input  logic                               axil_if,
    input  logic                               arst_n,
    input  proxy_pkg::result_t [num_lanes-1:0] lane_res,
    input  logic [num_lanes-1:0]               lane_out_valid,
    output logic [num_lanes-1:0]               lane_out_ready,
    output proxy_pkg::result_t                 out_res,
    output logic                               out_valid,
    input  logic                               out_ready
);
    localparam int ptr_w = (num_lanes > 1) ? $clog2(num_lanes) : 1;

    logic [ptr_w-1:0] ptr;
    logic             take;
    logic             sel_valid;

    // Output register free or draining this cycle
    assign take      = ~out_valid | out_ready;
    assign sel_valid = lane_out_valid[ptr];

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            lane_out_ready[i] = take && (ptr == ptr_w'(i));
        end
    end

    always_ff @(posedge axil_if) begin
        if (take && sel_valid) begin
            out_res <= lane_res[ptr];
        end
    end

    // Pointer follows the dispatcher order
    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            ptr       <= '0;
        end else if (take) begin
            out_valid <= sel_valid;
            if (sel_valid) begin
                ptr <= (ptr == ptr_w'(num_lanes - 1)) ? '0 : ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/match_lane.sv
`timescale 1ns/1ps
`default_nettype none

module match_lane #(
    parameter int tbl_depth = 8
) (
    input  logic                                  axil_if,
    input  logic                                  arst_n,
    input  proxy_pkg::tbl_entry_t [tbl_depth-1:0] tbl,
    input  proxy_pkg::desc_t                      desc,
    input  logic                                  in_valid,
    output logic                                  in_ready,
    output proxy_pkg::result_t                    res,
    output logic                                  out_valid,
    input  logic                                  out_ready
);
    import proxy_pkg::*;

    logic                 shift;
    logic                 s1_en;
    logic                 s1_valid;
    desc_t                s1_desc;
    logic [tbl_depth-1:0] s1_hit;
    logic [tbl_depth-1:0] hit;
    action_u              sel_act;

    // Both stages move when the output slot frees up
    assign shift    = ~out_valid | out_ready;
    assign s1_en    = ~s1_valid | shift;
    assign in_ready = s1_en;

    // ========================================================================
    // Stage one, key compare
    // ========================================================================
    always_comb begin
        for (int i = 0; i < tbl_depth; i++) begin
            hit[i] = tbl[i].valid && (tbl[i].key == desc.key);
        end
    end

    always_ff @(posedge axil_if) begin
        if (s1_en) begin
            s1_desc <= desc;
            s1_hit  <= hit;
        end
    end

    // ========================================================================
    // Stage two, priority select
    // ========================================================================
    always_comb begin
        sel_act.punt.tag    = 1'b0;
        sel_act.punt.pad    = '0;
        sel_act.punt.reason = punt_miss;
        // Walk downwards so the lowest index wins
        for (int i = tbl_depth - 1; i >= 0; i--) begin
            if (s1_hit[i]) begin
                sel_act = tbl[i].act;
            end
        end
    end

    always_ff @(posedge axil_if) begin
        if (shift) begin
            res.desc <= s1_desc;
            res.act  <= sel_act;
        end
    end

    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (s1_en) begin
                s1_valid <= in_valid;
            end
            if (shift) begin
                out_valid <= s1_valid;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/desc_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module desc_dispatch #(
    parameter int num_lanes = 4
) (
    input  logic                             axil_if,
    input  logic                             arst_n,
    input  proxy_pkg::desc_t                 in_desc,
    input  logic                             in_valid,
    output logic                             in_ready,
    output proxy_pkg::desc_t [num_lanes-1:0] lane_desc,
    output logic [num_lanes-1:0]             lane_in_valid,
    input  logic [num_lanes-1:0]             lane_in_ready
);
    localparam int ptr_w = (num_lanes > 1) ? $clog2(num_lanes) : 1;

    logic [ptr_w-1:0] ptr;
    logic             in_fire;

    // Only the selected lane sees a valid descriptor
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            lane_desc[i]     = in_desc;
            lane_in_valid[i] = in_valid && (ptr == ptr_w'(i));
        end
    end

    assign in_ready = lane_in_ready[ptr];
    assign in_fire  = in_valid & in_ready;

    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= '0;
        end else if (in_fire) begin
            if (ptr == ptr_w'(num_lanes - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/mgmt_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mgmt_regs #(
    parameter int tbl_depth = 8
) (
    input  logic                                  axil_if,
    input  logic                                  arst_n,
    input  proxy_pkg::axil_req_t                  axil_req,
    output proxy_pkg::axil_rsp_t                  axil_rsp,
    output proxy_pkg::tbl_entry_t [tbl_depth-1:0] tbl,
    input  logic                                  out_fire,
    input  proxy_pkg::action_u                    out_action
);
    import proxy_pkg::*;

    logic                 wr_fire;
    logic                 rd_fire;
    logic                 bvalid;
    logic                 rvalid;
    logic [31:0]          rdata;
    logic [31:0]          rd_word;
    logic [tbl_depth-1:0] wr_sel;
    logic [tbl_depth-1:0] ent_valid;
    logic [15:0]          ent_key [tbl_depth];
    action_u              ent_act [tbl_depth];
    logic [31:0]          fwd_cnt;
    logic [31:0]          punt_cnt;

    // ========================================================================
    // Handshake, one transaction outstanding per direction
    // ========================================================================
    assign wr_fire = axil_req.awvalid & axil_req.wvalid & ~bvalid;
    assign rd_fire = axil_req.arvalid & ~rvalid;

    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axil_if) begin
        if (rd_fire) begin
            rdata <= rd_word;
        end
    end

    // ========================================================================
    // Lookup table
    // ========================================================================
    always_comb begin
        for (int i = 0; i < tbl_depth; i++) begin
            wr_sel[i] = (axil_req.awaddr == tbl_base + 8'(4 * i));
        end
    end

    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            ent_valid <= '0;
        end else if (wr_fire) begin
            for (int i = 0; i < tbl_depth; i++) begin
                if (wr_sel[i]) begin
                    ent_valid[i] <= axil_req.wdata[31];
                end
            end
        end
    end

    always_ff @(posedge axil_if) begin
        for (int i = 0; i < tbl_depth; i++) begin
            if (wr_fire && wr_sel[i]) begin
                ent_key[i] <= axil_req.wdata[15:0];
                ent_act[i] <= axil_req.wdata[23:16];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < tbl_depth; i++) begin
            tbl[i].valid = ent_valid[i];
            tbl[i].key   = ent_key[i];
            tbl[i].act   = ent_act[i];
        end
    end

    // Unmapped addresses read as zero
    always_comb begin
        rd_word = '0;
        for (int i = 0; i < tbl_depth; i++) begin
            if (axil_req.araddr == tbl_base + 8'(4 * i)) begin
                rd_word = {ent_valid[i], 7'd0, ent_act[i], ent_key[i]};
            end
        end
        if (axil_req.araddr == reg_fwd_cnt) begin
            rd_word = fwd_cnt;
        end
        if (axil_req.araddr == reg_punt_cnt) begin
            rd_word = punt_cnt;
        end
    end

    // Statistics, split by the action tag
    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            fwd_cnt  <= '0;
            punt_cnt <= '0;
        end else if (out_fire) begin
            if (out_action.fwd.tag) begin
                fwd_cnt <= fwd_cnt + 32'd1;
            end else begin
                punt_cnt <= punt_cnt + 32'd1;
            end
        end
    end

    assign axil_rsp.awready = wr_fire;
    assign axil_rsp.wready  = wr_fire;
    assign axil_rsp.bvalid  = bvalid;
    assign axil_rsp.arready = rd_fire;
    assign axil_rsp.rvalid  = rvalid;
    assign axil_rsp.rdata   = rdata;

endmodule

`default_nettype wire

// File: hdl/proxy_pkg.sv
`default_nettype none

package proxy_pkg;

    typedef logic [1:0] port_t;

    // Descriptor as it arrives from a switch port
    typedef struct packed {
        port_t       src_port;
        logic [15:0] key;
        logic [13:0] len;
    } desc_t;

    // Action word, top bit selects the view
    typedef struct packed {
        logic       tag;
        logic [4:0] pad;
        port_t      egress;
    } fwd_act_t;

    typedef struct packed {
        logic       tag;
        logic [2:0] pad;
        logic [3:0] reason;
    } punt_act_t;

    typedef union packed {
        fwd_act_t  fwd;
        punt_act_t punt;
    } action_u;

    localparam logic [3:0] punt_miss = 4'd1;

    typedef struct packed {
        logic        valid;
        logic [15:0] key;
        action_u     act;
    } tbl_entry_t;

    typedef struct packed {
        desc_t   desc;
        action_u act;
    } result_t;

    // ========================================================================
    // Management port
    // ========================================================================
    typedef struct packed {
        logic [7:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic        wvalid;
        logic        bready;
        logic [7:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
    } axil_rsp_t;

    // One word per table entry starting at tbl_base
    localparam logic [7:0] tbl_base     = 8'h00;
    localparam logic [7:0] reg_fwd_cnt  = 8'h40;
    localparam logic [7:0] reg_punt_cnt = 8'h44;

endpackage

`default_nettype wire
